//--- source/xy_scope_pkg.sv
`default_nettype none

package xy_scope_pkg;

  // ========================================================================
  // framebuffer cell layout
  // ========================================================================

  // three colour-enable bits sit above the intensity field
  localparam int cell_intensity_bits = 4;
  localparam int cell_bits           = cell_intensity_bits + 3;
  localparam int cell_blu_bit        = cell_intensity_bits;
  localparam int cell_grn_bit        = cell_intensity_bits + 1;
  localparam int cell_red_bit        = cell_intensity_bits + 2;

  // ========================================================================
  // control port register map
  // ========================================================================

  localparam int wb_data_bits  = 16;
  localparam int reg_addr_bits = 2;
  localparam int fade_bits     = 8;
  localparam int count_bits    = 16;

  localparam logic [reg_addr_bits-1:0] reg_ctrl_addr   = 2'd0;
  localparam logic [reg_addr_bits-1:0] reg_fade_addr   = 2'd1;
  localparam logic [reg_addr_bits-1:0] reg_count_addr  = 2'd2;
  localparam logic [reg_addr_bits-1:0] reg_status_addr = 2'd3;

  // bit 1 of ctrl self-clears and is never stored
  localparam int ctrl_enable_bit = 0;
  localparam int ctrl_clear_bit  = 1;

endpackage

`default_nettype wire

//--- source/raster_timing.sv
`timescale 1ns/1ps
`default_nettype none

module raster_timing #(
  parameter int H_ACTIVE = 512,
  parameter int H_FRONT  = 16,
  parameter int H_SYNC   = 64,
  parameter int H_BACK   = 48,
  parameter int V_ACTIVE = 256,
  parameter int V_FRONT  = 3,
  parameter int V_SYNC   = 4,
  parameter int V_BACK   = 13,
  localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK,
  localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK,
  localparam int H_BITS  = $clog2(H_TOTAL),
  localparam int V_BITS  = $clog2(V_TOTAL)
) (
  input  logic              pixel_clk,
  input  logic              rst_n,
  output logic [H_BITS-1:0] h_count,
  output logic [V_BITS-1:0] v_count,
  output logic              active,
  output logic              hsync_raw,
  output logic              vsync_raw,
  output logic              frame_start
);

  localparam int H_SYNC_START = H_ACTIVE + H_FRONT;
  localparam int H_SYNC_END   = H_SYNC_START + H_SYNC;
  localparam int V_SYNC_START = V_ACTIVE + V_FRONT;
  localparam int V_SYNC_END   = V_SYNC_START + V_SYNC;

  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      h_count <= '0;
      v_count <= '0;
    end else if (h_count == H_BITS'(H_TOTAL - 1)) begin
      h_count <= '0;
      if (v_count == V_BITS'(V_TOTAL - 1)) begin
        v_count <= '0;
      end else begin
        v_count <= v_count + 1'b1;
      end
    end else begin
      h_count <= h_count + 1'b1;
    end
  end

  // sync pulses are active low, placed after the front porch
  assign hsync_raw   = !((h_count >= H_SYNC_START) && (h_count < H_SYNC_END));
  assign vsync_raw   = !((v_count >= V_SYNC_START) && (v_count < V_SYNC_END));
  assign active      = (h_count < H_ACTIVE) && (v_count < V_ACTIVE);
  assign frame_start = (h_count == '0) && (v_count == '0);

  assert property (@(posedge pixel_clk) disable iff (!rst_n)
    h_count < H_TOTAL);

endmodule

`default_nettype wire

//--- source/trace_plotter.sv
`timescale 1ns/1ps
`default_nettype none

module trace_plotter #(
  parameter int ADC_WIDTH  = 10,
  parameter int FB_X_BITS  = 8,
  parameter int FB_Y_BITS  = 7,
  localparam int ADDR_BITS = FB_X_BITS + FB_Y_BITS
) (
  input  logic                               pixel_clk,
  input  logic                               rst_n,
  input  logic [ADC_WIDTH-1:0]               sample_x,
  input  logic [ADC_WIDTH-1:0]               sample_y,
  input  logic                               sample_red,
  input  logic                               sample_grn,
  input  logic                               sample_blu,
  input  logic                               sample_valid,
  input  logic                               plot_enable,
  input  logic                               plot_grant,
  output logic                               sample_ready,
  output logic                               plot_req,
  output logic [ADDR_BITS-1:0]               plot_addr,
  output logic [xy_scope_pkg::cell_bits-1:0] plot_cell,
  output logic                               sample_written
);

  import xy_scope_pkg::*;

  logic [FB_X_BITS-1:0] col;
  logic [FB_Y_BITS-1:0] row;
  logic [2:0]           rgb_en;
  logic                 keep;
  logic                 pending;
  logic                 accept;
  logic                 req_next;

  assign accept   = sample_valid && sample_ready;
  // a held sample turns into a request one cycle after capture
  assign req_next = pending ? keep : (plot_req && !plot_grant);

  // the holder keeps only the top bits of each axis
  always_ff @(posedge pixel_clk) begin
    if (accept) begin
      col    <= sample_x[ADC_WIDTH-1 -: FB_X_BITS];
      row    <= sample_y[ADC_WIDTH-1 -: FB_Y_BITS];
      rgb_en <= {sample_red, sample_grn, sample_blu};
      keep   <= plot_enable;
    end
  end

  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      pending        <= 1'b0;
      plot_req       <= 1'b0;
      sample_ready   <= 1'b0;
      sample_written <= 1'b0;
    end else begin
      pending        <= accept;
      plot_req       <= req_next;
      sample_ready   <= !accept && !req_next;
      sample_written <= plot_req && plot_grant;
    end
  end

  // row times cells per row plus column, cells per row being a power of two
  assign plot_addr = {row, col};

  always_comb begin
    plot_cell                          = '0;
    plot_cell[cell_intensity_bits-1:0] = '1;
    plot_cell[cell_red_bit]            = rgb_en[2];
    plot_cell[cell_grn_bit]            = rgb_en[1];
    plot_cell[cell_blu_bit]            = rgb_en[0];
  end

  assert property (@(posedge pixel_clk) disable iff (!rst_n)
    plot_req && !plot_grant |=> plot_req && $stable(plot_addr) && $stable(plot_cell));

endmodule

`default_nettype wire

//--- source/frame_store.sv
`timescale 1ns/1ps
`default_nettype none

module frame_store #(
  parameter int H_ACTIVE    = 512,
  parameter int H_FRONT     = 16,
  parameter int H_SYNC      = 64,
  parameter int H_BACK      = 48,
  parameter int V_ACTIVE    = 256,
  parameter int V_FRONT     = 3,
  parameter int V_SYNC      = 4,
  parameter int V_BACK      = 13,
  parameter int FB_X_BITS   = 8,
  parameter int FB_Y_BITS   = 7,
  parameter int SCALE_SHIFT = 1,
  parameter int COLOR_WIDTH = 4,
  localparam int H_BITS     = $clog2(H_ACTIVE + H_FRONT + H_SYNC + H_BACK),
  localparam int V_BITS     = $clog2(V_ACTIVE + V_FRONT + V_SYNC + V_BACK),
  localparam int ADDR_BITS  = FB_X_BITS + FB_Y_BITS
) (
  input  logic                               pixel_clk,
  input  logic                               rst_n,
  input  logic [H_BITS-1:0]                  h_count,
  input  logic [V_BITS-1:0]                  v_count,
  input  logic                               active,
  input  logic                               hsync_raw,
  input  logic                               vsync_raw,
  input  logic                               frame_start,
  input  logic                               plot_req,
  input  logic [ADDR_BITS-1:0]               plot_addr,
  input  logic [xy_scope_pkg::cell_bits-1:0] plot_cell,
  input  logic [xy_scope_pkg::fade_bits-1:0] fade_period,
  input  logic                               clear_start,
  output logic                               plot_grant,
  output logic                               clear_busy,
  output logic [COLOR_WIDTH-1:0]             vga_red,
  output logic [COLOR_WIDTH-1:0]             vga_grn,
  output logic [COLOR_WIDTH-1:0]             vga_blu,
  output logic                               vga_hsync,
  output logic                               vga_vsync
);

  import xy_scope_pkg::*;

  localparam int CELLS = 1 << ADDR_BITS;

  logic [cell_bits-1:0]           mem [CELLS];
  logic [cell_bits-1:0]           rd_cell;
  logic [cell_bits-1:0]           wr_data;
  logic [cell_intensity_bits-1:0] rd_int;
  logic [COLOR_WIDTH-1:0]         pix_int;
  logic [ADDR_BITS-1:0]           rd_addr;
  logic [ADDR_BITS-1:0]           rd_addr_q;
  logic [ADDR_BITS-1:0]           wr_addr;
  logic [ADDR_BITS-1:0]           clr_addr;
  logic [fade_bits-1:0]           frame_cnt;
  logic                           fade_frame;
  logic                           first_pix;
  logic                           first_q;
  logic                           fade_we;
  logic                           wr_en;
  logic                           active_q;
  logic                           hsync_q;
  logic                           vsync_q;

  assign rd_addr   = {v_count[SCALE_SHIFT +: FB_Y_BITS], h_count[SCALE_SHIFT +: FB_X_BITS]};
  assign first_pix = active
                   && ((h_count & H_BITS'((1 << SCALE_SHIFT) - 1)) == '0)
                   && ((v_count & V_BITS'((1 << SCALE_SHIFT) - 1)) == '0);
  assign rd_int    = rd_cell[cell_intensity_bits-1:0];
  assign pix_int   = COLOR_WIDTH'(rd_int);
  // cells already at zero need no write-back, which frees the port for plots
  assign fade_we   = first_q && fade_frame && (rd_int != '0);

  // ========================================================================
  // single write port shared by clear, fade and plot
  // ========================================================================

  always_comb begin
    wr_en   = 1'b1;
    wr_addr = clr_addr;
    wr_data = '0;
    if (!clear_busy && fade_we) begin
      wr_addr = rd_addr_q;
      wr_data = {rd_cell[cell_bits-1:cell_intensity_bits], rd_int - 1'b1};
    end else if (!clear_busy) begin
      wr_en   = plot_req;
      wr_addr = plot_addr;
      wr_data = plot_cell;
    end
  end

  assign plot_grant = plot_req && !clear_busy && !fade_we;

  initial begin
    for (int i = 0; i < CELLS; i++) begin
      mem[i] = '0;
    end
  end

  always_ff @(posedge pixel_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
    rd_cell   <= mem[rd_addr];
    rd_addr_q <= rd_addr;
  end

  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      clear_busy <= 1'b0;
      clr_addr   <= '0;
    end else if (clear_busy) begin
      clr_addr <= clr_addr + 1'b1;
      if (&clr_addr) begin
        clear_busy <= 1'b0;
      end
    end else if (clear_start) begin
      clear_busy <= 1'b1;
      clr_addr   <= '0;
    end
  end

  // every fade_period frames the next frame becomes a fade frame
  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      frame_cnt  <= '0;
      fade_frame <= 1'b0;
    end else if (frame_start) begin
      if (fade_period == '0) begin
        frame_cnt  <= '0;
        fade_frame <= 1'b0;
      end else if (frame_cnt + 1'b1 >= fade_period) begin
        frame_cnt  <= '0;
        fade_frame <= 1'b1;
      end else begin
        frame_cnt  <= frame_cnt + 1'b1;
        fade_frame <= 1'b0;
      end
    end
  end

  // ========================================================================
  // pixel output, two stages behind the raster counters
  // ========================================================================

  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      active_q  <= 1'b0;
      first_q   <= 1'b0;
      hsync_q   <= 1'b1;
      vsync_q   <= 1'b1;
      vga_hsync <= 1'b1;
      vga_vsync <= 1'b1;
      vga_red   <= '0;
      vga_grn   <= '0;
      vga_blu   <= '0;
    end else begin
      active_q  <= active;
      first_q   <= first_pix;
      hsync_q   <= hsync_raw;
      vsync_q   <= vsync_raw;
      vga_hsync <= hsync_q;
      vga_vsync <= vsync_q;
      vga_red   <= (active_q && rd_cell[cell_red_bit]) ? pix_int : '0;
      vga_grn   <= (active_q && rd_cell[cell_grn_bit]) ? pix_int : '0;
      vga_blu   <= (active_q && rd_cell[cell_blu_bit]) ? pix_int : '0;
    end
  end

  // no plot may land once a clear has been requested until the sweep is done
  assert property (@(posedge pixel_clk) disable iff (!rst_n)
    clear_start |=> (!plot_grant until !clear_busy));

endmodule

`default_nettype wire

//--- source/scope_regs.sv
`timescale 1ns/1ps
`default_nettype none

module scope_regs (
  input  logic                                   pixel_clk,
  input  logic                                   rst_n,
  input  logic                                   wb_cyc,
  input  logic                                   wb_stb,
  input  logic                                   wb_we,
  input  logic [xy_scope_pkg::reg_addr_bits-1:0] wb_adr,
  input  logic [xy_scope_pkg::wb_data_bits-1:0]  wb_dat_i,
  input  logic                                   clear_busy,
  input  logic                                   sample_written,
  output logic [xy_scope_pkg::wb_data_bits-1:0]  wb_dat_o,
  output logic                                   wb_ack,
  output logic                                   plot_enable,
  output logic [xy_scope_pkg::fade_bits-1:0]     fade_period,
  output logic                                   clear_start
);

  import xy_scope_pkg::*;

  logic [count_bits-1:0]   sample_count;
  logic [wb_data_bits-1:0] rd_data;
  logic                    req;
  logic                    wr;

  // a new cycle is taken only when no ack is pending, so acks are single pulses
  assign req = wb_cyc && wb_stb && !wb_ack;
  assign wr  = req && wb_we;

  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      wb_ack      <= 1'b0;
      plot_enable <= 1'b0;
      fade_period <= '0;
      clear_start <= 1'b0;
    end else begin
      wb_ack      <= req;
      clear_start <= wr && (wb_adr == reg_ctrl_addr) && wb_dat_i[ctrl_clear_bit];
      if (wr && (wb_adr == reg_ctrl_addr)) begin
        plot_enable <= wb_dat_i[ctrl_enable_bit];
      end
      if (wr && (wb_adr == reg_fade_addr)) begin
        fade_period <= wb_dat_i[fade_bits-1:0];
      end
    end
  end

  // wraps at 16 bits, and any write to its address zeroes it
  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      sample_count <= '0;
    end else if (wr && (wb_adr == reg_count_addr)) begin
      sample_count <= '0;
    end else if (sample_written) begin
      sample_count <= sample_count + 1'b1;
    end
  end

  always_comb begin
    rd_data = '0;
    case (wb_adr)
      reg_ctrl_addr:   rd_data[ctrl_enable_bit] = plot_enable;
      reg_fade_addr:   rd_data[fade_bits-1:0]   = fade_period;
      reg_count_addr:  rd_data                  = sample_count;
      reg_status_addr: rd_data[0]               = clear_busy;
      default:         rd_data                  = '0;
    endcase
  end

  always_ff @(posedge pixel_clk) begin
    if (req) begin
      wb_dat_o <= rd_data;
    end
  end

  assert property (@(posedge pixel_clk) disable iff (!rst_n)
    wb_ack |=> !wb_ack);

endmodule

`default_nettype wire

//--- source/xy_scope_top.sv
`timescale 1ns/1ps
`default_nettype none

module xy_scope_top #(
  parameter int H_ACTIVE    = 512,
  parameter int H_FRONT     = 16,
  parameter int H_SYNC      = 64,
  parameter int H_BACK      = 48,
  parameter int V_ACTIVE    = 256,
  parameter int V_FRONT     = 3,
  parameter int V_SYNC      = 4,
  parameter int V_BACK      = 13,
  parameter int FB_X_BITS   = 8,
  parameter int FB_Y_BITS   = 7,
  parameter int SCALE_SHIFT = 1,
  parameter int ADC_WIDTH   = 10,
  parameter int COLOR_WIDTH = 4
) (
  input  logic                                   pixel_clk,
  input  logic                                   rst_n,
  input  logic [ADC_WIDTH-1:0]                   sample_x,
  input  logic [ADC_WIDTH-1:0]                   sample_y,
  input  logic                                   sample_red,
  input  logic                                   sample_grn,
  input  logic                                   sample_blu,
  input  logic                                   sample_valid,
  output logic                                   sample_ready,
  input  logic                                   wb_cyc,
  input  logic                                   wb_stb,
  input  logic                                   wb_we,
  input  logic [xy_scope_pkg::reg_addr_bits-1:0] wb_adr,
  input  logic [xy_scope_pkg::wb_data_bits-1:0]  wb_dat_i,
  output logic [xy_scope_pkg::wb_data_bits-1:0]  wb_dat_o,
  output logic                                   wb_ack,
  output logic [COLOR_WIDTH-1:0]                 vga_red,
  output logic [COLOR_WIDTH-1:0]                 vga_grn,
  output logic [COLOR_WIDTH-1:0]                 vga_blu,
  output logic                                   vga_hsync,
  output logic                                   vga_vsync
);

  import xy_scope_pkg::*;

  localparam int H_BITS    = $clog2(H_ACTIVE + H_FRONT + H_SYNC + H_BACK);
  localparam int V_BITS    = $clog2(V_ACTIVE + V_FRONT + V_SYNC + V_BACK);
  localparam int ADDR_BITS = FB_X_BITS + FB_Y_BITS;

  logic [H_BITS-1:0]    h_count;
  logic [V_BITS-1:0]    v_count;
  logic                 active;
  logic                 hsync_raw;
  logic                 vsync_raw;
  logic                 frame_start;
  logic                 plot_req;
  logic                 plot_grant;
  logic [ADDR_BITS-1:0] plot_addr;
  logic [cell_bits-1:0] plot_cell;
  logic                 sample_written;
  logic                 plot_enable;
  logic [fade_bits-1:0] fade_period;
  logic                 clear_start;
  logic                 clear_busy;

  raster_timing #(
    .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
    .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
  ) u_raster (
    .pixel_clk  (pixel_clk),
    .rst_n      (rst_n),
    .h_count    (h_count),
    .v_count    (v_count),
    .active     (active),
    .hsync_raw  (hsync_raw),
    .vsync_raw  (vsync_raw),
    .frame_start(frame_start)
  );

  trace_plotter #(
    .ADC_WIDTH(ADC_WIDTH),
    .FB_X_BITS(FB_X_BITS),
    .FB_Y_BITS(FB_Y_BITS)
  ) u_plotter (
    .pixel_clk     (pixel_clk),
    .rst_n         (rst_n),
    .sample_x      (sample_x),
    .sample_y      (sample_y),
    .sample_red    (sample_red),
    .sample_grn    (sample_grn),
    .sample_blu    (sample_blu),
    .sample_valid  (sample_valid),
    .plot_enable   (plot_enable),
    .plot_grant    (plot_grant),
    .sample_ready  (sample_ready),
    .plot_req      (plot_req),
    .plot_addr     (plot_addr),
    .plot_cell     (plot_cell),
    .sample_written(sample_written)
  );

  frame_store #(
    .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
    .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK),
    .FB_X_BITS(FB_X_BITS), .FB_Y_BITS(FB_Y_BITS),
    .SCALE_SHIFT(SCALE_SHIFT), .COLOR_WIDTH(COLOR_WIDTH)
  ) u_store (
    .pixel_clk  (pixel_clk),
    .rst_n      (rst_n),
    .h_count    (h_count),
    .v_count    (v_count),
    .active     (active),
    .hsync_raw  (hsync_raw),
    .vsync_raw  (vsync_raw),
    .frame_start(frame_start),
    .plot_req   (plot_req),
    .plot_addr  (plot_addr),
    .plot_cell  (plot_cell),
    .fade_period(fade_period),
    .clear_start(clear_start),
    .plot_grant (plot_grant),
    .clear_busy (clear_busy),
    .vga_red    (vga_red),
    .vga_grn    (vga_grn),
    .vga_blu    (vga_blu),
    .vga_hsync  (vga_hsync),
    .vga_vsync  (vga_vsync)
  );

  scope_regs u_regs (
    .pixel_clk     (pixel_clk),
    .rst_n         (rst_n),
    .wb_cyc        (wb_cyc),
    .wb_stb        (wb_stb),
    .wb_we         (wb_we),
    .wb_adr        (wb_adr),
    .wb_dat_i      (wb_dat_i),
    .clear_busy    (clear_busy),
    .sample_written(sample_written),
    .wb_dat_o      (wb_dat_o),
    .wb_ack        (wb_ack),
    .plot_enable   (plot_enable),
    .fade_period   (fade_period),
    .clear_start   (clear_start)
  );

endmodule

`default_nettype wire

//--- testbench/tb_xy_scope.sv
`timescale 1ns/1ps
`default_nettype none

module tb_xy_scope;

  import xy_scope_pkg::*;

  // each active axis is the cell count shifted left by SCALE_SHIFT
  localparam int H_ACTIVE    = 32;
  localparam int H_FRONT     = 2;
  localparam int H_SYNC      = 4;
  localparam int H_BACK      = 2;
  localparam int V_ACTIVE    = 16;
  localparam int V_FRONT     = 1;
  localparam int V_SYNC      = 2;
  localparam int V_BACK      = 1;
  localparam int FB_X_BITS   = 4;
  localparam int FB_Y_BITS   = 3;
  localparam int SCALE_SHIFT = 1;
  localparam int ADC_WIDTH   = 10;
  localparam int COLOR_WIDTH = 4;
  localparam int H_TOTAL     = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
  localparam int V_TOTAL     = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
  localparam int CELLS       = 1 << (FB_X_BITS + FB_Y_BITS);
  localparam int WAIT_LIMIT  = 2 * H_TOTAL * V_TOTAL;

  logic                     pixel_clk;
  logic                     rst_n;
  logic [ADC_WIDTH-1:0]     sample_x;
  logic [ADC_WIDTH-1:0]     sample_y;
  logic                     sample_red;
  logic                     sample_grn;
  logic                     sample_blu;
  logic                     sample_valid;
  logic                     sample_ready;
  logic                     wb_cyc;
  logic                     wb_stb;
  logic                     wb_we;
  logic [reg_addr_bits-1:0] wb_adr;
  logic [wb_data_bits-1:0]  wb_dat_i;
  logic [wb_data_bits-1:0]  wb_dat_o;
  logic                     wb_ack;
  logic [COLOR_WIDTH-1:0]   vga_red;
  logic [COLOR_WIDTH-1:0]   vga_grn;
  logic [COLOR_WIDTH-1:0]   vga_blu;
  logic                     vga_hsync;
  logic                     vga_vsync;

  int                       errors;
  int                       frames;
  int                       xfers;
  logic                     plot_on;
  logic                     check_en;
  logic                     fade_mode;
  logic [3*COLOR_WIDTH-1:0] exp_rgb [CELLS];
  logic [3*COLOR_WIDTH-1:0] exp_pix;
  logic [3*COLOR_WIDTH-1:0] vga_rgb;

  logic hs_prev;
  logic vs_prev;
  logic h_seen;
  logic pos_ok;
  logic h_fell;
  logic h_rose;
  logic v_fell;
  logic v_rose;
  logic visible;
  int   h_gap;
  int   hs_low;
  int   vs_low;
  int   h_pos;
  int   v_pos;
  int   cur_h;
  int   cur_v;

  xy_scope_top #(
    .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
    .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK),
    .FB_X_BITS(FB_X_BITS), .FB_Y_BITS(FB_Y_BITS), .SCALE_SHIFT(SCALE_SHIFT),
    .ADC_WIDTH(ADC_WIDTH), .COLOR_WIDTH(COLOR_WIDTH)
  ) uut (
    .pixel_clk(pixel_clk), .rst_n(rst_n),
    .sample_x(sample_x), .sample_y(sample_y), .sample_red(sample_red),
    .sample_grn(sample_grn), .sample_blu(sample_blu),
    .sample_valid(sample_valid), .sample_ready(sample_ready),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
    .wb_dat_i(wb_dat_i), .wb_dat_o(wb_dat_o), .wb_ack(wb_ack),
    .vga_red(vga_red), .vga_grn(vga_grn), .vga_blu(vga_blu),
    .vga_hsync(vga_hsync), .vga_vsync(vga_vsync)
  );

  initial begin
    pixel_clk = 1'b0;
    forever #20 pixel_clk = ~pixel_clk;
  end

  // ==========================================================================
  // raster position recovered from the sync outputs
  // ==========================================================================

  assign vga_rgb = {vga_red, vga_grn, vga_blu};
  assign h_fell  = hs_prev && !vga_hsync;
  assign h_rose  = !hs_prev && vga_hsync;
  assign v_fell  = vs_prev && !vga_vsync;
  assign v_rose  = !vs_prev && vga_vsync;

  always_comb begin
    cur_h   = h_fell ? H_ACTIVE + H_FRONT : h_pos;
    cur_v   = v_fell ? V_ACTIVE + V_FRONT : v_pos;
    visible = pos_ok && (cur_h < H_ACTIVE) && (cur_v < V_ACTIVE);
    // row times cells per row plus column
    exp_pix = visible ? exp_rgb[(cur_v >> SCALE_SHIFT) * (1 << FB_X_BITS)
                                + (cur_h >> SCALE_SHIFT)] : '0;
  end

  always @(posedge pixel_clk) begin
    if (!rst_n) begin
      hs_prev <= 1'b1;
      vs_prev <= 1'b1;
      h_seen  <= 1'b0;
      pos_ok  <= 1'b0;
      h_gap   <= 0;
      hs_low  <= 0;
      vs_low  <= 0;
      h_pos   <= 0;
      v_pos   <= 0;
    end else begin
      hs_prev <= vga_hsync;
      vs_prev <= vga_vsync;
      h_gap   <= h_fell ? 1 : h_gap + 1;
      hs_low  <= vga_hsync ? 0 : hs_low + 1;
      vs_low  <= vga_vsync ? 0 : vs_low + 1;
      h_pos   <= (cur_h + 1) % H_TOTAL;
      v_pos   <= (cur_h == H_TOTAL - 1) ? (cur_v + 1) % V_TOTAL : cur_v;
      if (h_fell) begin
        h_seen <= 1'b1;
      end
      if (v_fell) begin
        pos_ok <= 1'b1;
      end
    end
  end

  always @(posedge pixel_clk) begin
    if (rst_n && sample_valid && sample_ready && plot_on) begin
      xfers <= xfers + 1;
    end
  end

  assert property (@(posedge pixel_clk) disable iff (!rst_n)
    h_fell && h_seen |-> h_gap == H_TOTAL)
  else begin
    errors++;
    $display("FAIL %0t vga_hsync period expected %0d got %0d", $time, H_TOTAL, $sampled(h_gap));
  end

  assert property (@(posedge pixel_clk) disable iff (!rst_n)
    h_rose |-> hs_low == H_SYNC)
  else begin
    errors++;
    $display("FAIL %0t vga_hsync low width expected %0d got %0d", $time, H_SYNC,
             $sampled(hs_low));
  end

  assert property (@(posedge pixel_clk) disable iff (!rst_n)
    v_rose |-> vs_low == V_SYNC * H_TOTAL)
  else begin
    errors++;
    $display("FAIL %0t vga_vsync low width expected %0d got %0d", $time, V_SYNC * H_TOTAL,
             $sampled(vs_low));
  end

  assert property (@(posedge pixel_clk) disable iff (!rst_n)
    pos_ok && !visible |-> vga_rgb == '0)
  else begin
    errors++;
    $display("FAIL %0t vga_rgb in blanking expected 0 got %h", $time, $sampled(vga_rgb));
  end

  // during fading only the top line of a cell still shows the pre-fade value
  assert property (@(posedge pixel_clk) disable iff (!rst_n)
    visible && check_en && (!fade_mode || (cur_v % (1 << SCALE_SHIFT)) == 0)
      |-> vga_rgb == exp_pix)
  else begin
    errors++;
    $display("FAIL %0t vga_rgb expected %h got %h", $time, $sampled(exp_pix),
             $sampled(vga_rgb));
  end

  // ==========================================================================
  // helpers
  // ==========================================================================

  function automatic int cell_of(input logic [ADC_WIDTH-1:0] x, input logic [ADC_WIDTH-1:0] y);
    return int'(y >> (ADC_WIDTH - FB_Y_BITS)) * (1 << FB_X_BITS)
           + int'(x >> (ADC_WIDTH - FB_X_BITS));
  endfunction

  function automatic logic [3*COLOR_WIDTH-1:0] pixel_value(input logic [2:0] rgb, input int lvl);
    logic [COLOR_WIDTH-1:0] i;
    i = COLOR_WIDTH'(lvl);
    return {rgb[2] ? i : 4'h0, rgb[1] ? i : 4'h0, rgb[0] ? i : 4'h0};
  endfunction

  task automatic finish_run(input logic timed_out);
    $display("frames %0d, transfers %0d, errors %0d", frames, xfers, errors);
    if (errors == 0 && !timed_out) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  endtask

  task automatic expect_read(input string name, input logic [wb_data_bits-1:0] want,
                             input logic [wb_data_bits-1:0] got);
    assert (got === want)
    else begin
      errors++;
      $display("FAIL %0t %s expected %h got %h", $time, name, want, got);
    end
  endtask

  task automatic wb_access(input logic we, input logic [reg_addr_bits-1:0] adr,
                           input logic [wb_data_bits-1:0] wdat,
                           output logic [wb_data_bits-1:0] rdat);
    int n;
    n        = 0;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_i = wdat;
    @(negedge pixel_clk);
    while (!wb_ack && n < 16) begin
      @(negedge pixel_clk);
      n++;
    end
    rdat   = wb_dat_o;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    if (!wb_ack) begin
      $display("bus cycle to register %0d was never acknowledged", adr);
      finish_run(1'b1);
    end
  endtask

  task automatic wait_clear_done();
    logic [wb_data_bits-1:0] st;
    int n;
    n  = 0;
    st = '1;
    while (st[0] && n < 200) begin
      wb_access(1'b0, reg_status_addr, '0, st);
      n++;
    end
    if (st[0]) begin
      $display("clear busy never dropped");
      finish_run(1'b1);
    end
  endtask

  task automatic wait_vsync_fall();
    logic prev;
    int n;
    n    = 0;
    prev = vga_vsync;
    @(negedge pixel_clk);
    while (!(prev && !vga_vsync) && n < WAIT_LIMIT) begin
      prev = vga_vsync;
      @(negedge pixel_clk);
      n++;
    end
    if (prev && !vga_vsync) begin
      frames++;
    end else begin
      $display("no vsync pulse seen within two frame times");
      finish_run(1'b1);
    end
  endtask

  task automatic wait_ready();
    int n;
    n = 0;
    while (!sample_ready && n < WAIT_LIMIT) begin
      @(negedge pixel_clk);
      n++;
    end
    if (!sample_ready) begin
      $display("sample_ready stayed low");
      finish_run(1'b1);
    end
  endtask

  // valid stays high on return so that a burst can follow without a gap
  task automatic send_sample(input logic [ADC_WIDTH-1:0] x, input logic [ADC_WIDTH-1:0] y,
                             input logic [2:0] rgb);
    sample_x     = x;
    sample_y     = y;
    sample_red   = rgb[2];
    sample_grn   = rgb[1];
    sample_blu   = rgb[0];
    sample_valid = 1'b1;
    wait_ready();
    @(negedge pixel_clk);
  endtask

  task automatic reset_model();
    for (int i = 0; i < CELLS; i++) begin
      exp_rgb[i] = '0;
    end
  endtask

  task automatic check_frame();
    wait_vsync_fall();
    check_en = 1'b1;
    wait_vsync_fall();
    check_en = 1'b0;
  endtask

  // ==========================================================================
  // test sequence
  // ==========================================================================

  initial begin
    logic [wb_data_bits-1:0] rd;
    logic [ADC_WIDTH-1:0]    sx [3];
    logic [ADC_WIDTH-1:0]    sy [3];
    int                      lvl;
    int                      c;
    void'($urandom(28));
    rst_n        = 1'b0;
    sample_x     = '0;
    sample_y     = '0;
    sample_red   = 1'b0;
    sample_grn   = 1'b0;
    sample_blu   = 1'b0;
    sample_valid = 1'b0;
    wb_cyc       = 1'b0;
    wb_stb       = 1'b0;
    wb_we        = 1'b0;
    wb_adr       = '0;
    wb_dat_i     = '0;
    errors       = 0;
    frames       = 0;
    xfers        = 0;
    plot_on      = 1'b0;
    check_en     = 1'b0;
    fade_mode    = 1'b0;
    reset_model();
    repeat (5) @(negedge pixel_clk);
    rst_n = 1'b1;
    wait_vsync_fall();

    wb_access(1'b1, reg_fade_addr, 16'h00a5, rd);
    wb_access(1'b0, reg_fade_addr, '0, rd);
    expect_read("fade_period", 16'h00a5, rd);
    wb_access(1'b1, reg_fade_addr, 16'h0000, rd);
    wb_access(1'b1, reg_ctrl_addr, 16'h0003, rd);
    plot_on = 1'b1;
    wb_access(1'b0, reg_ctrl_addr, '0, rd);
    expect_read("ctrl", 16'h0001, rd);
    wait_clear_done();
    check_frame();

    for (int i = 0; i < 3; i++) begin
      sx[i] = ADC_WIDTH'($urandom());
      sy[i] = ADC_WIDTH'($urandom());
      send_sample(sx[i], sy[i], 3'b100 >> i);
      sample_valid = 1'b0;
    end
    wait_vsync_fall();
    for (int i = 0; i < 3; i++) begin
      exp_rgb[cell_of(sx[i], sy[i])] = pixel_value(3'b100 >> i, 15);
    end
    check_frame();

    // same samples with plotting off must leave the cleared screen dark
    wb_access(1'b1, reg_ctrl_addr, 16'h0002, rd);
    plot_on = 1'b0;
    wait_clear_done();
    reset_model();
    for (int i = 0; i < 3; i++) begin
      send_sample(sx[i], sy[i], 3'b100 >> i);
      sample_valid = 1'b0;
    end
    check_frame();

    wb_access(1'b1, reg_ctrl_addr, 16'h0001, rd);
    plot_on = 1'b1;
    sx[0] = ADC_WIDTH'($urandom());
    sy[0] = ADC_WIDTH'($urandom());
    c     = cell_of(sx[0], sy[0]);
    send_sample(sx[0], sy[0], 3'b101);
    sample_valid = 1'b0;
    wait_vsync_fall();
    lvl        = 15;
    exp_rgb[c] = pixel_value(3'b101, lvl);
    fade_mode  = 1'b1;
    check_en   = 1'b1;
    wb_access(1'b1, reg_fade_addr, 16'h0001, rd);
    repeat (18) begin
      wait_vsync_fall();
      lvl        = (lvl > 0) ? lvl - 1 : 0;
      exp_rgb[c] = pixel_value(3'b101, lvl);
    end
    check_en  = 1'b0;
    fade_mode = 1'b0;
    wb_access(1'b1, reg_fade_addr, 16'h0000, rd);

    // burst while a clear holds off the write port
    wb_access(1'b1, reg_count_addr, 16'h0000, rd);
    xfers = 0;
    wb_access(1'b1, reg_ctrl_addr, 16'h0003, rd);
    for (int i = 0; i < 24; i++) begin
      send_sample(ADC_WIDTH'($urandom()), ADC_WIDTH'($urandom()), 3'($urandom()));
    end
    sample_valid = 1'b0;
    wait_ready();
    // the count register trails the granted write by one cycle
    repeat (2) @(negedge pixel_clk);
    wb_access(1'b0, reg_count_addr, '0, rd);
    expect_read("sample_count", wb_data_bits'(xfers), rd);
    finish_run(1'b0);
  end

endmodule

`default_nettype wire

//--- list.f
source/xy_scope_pkg.sv
source/raster_timing.sv
source/trace_plotter.sv
source/frame_store.sv
source/scope_regs.sv
source/xy_scope_top.sv
testbench/tb_xy_scope.sv

//--- Bender.yml
package:
  name: xy_scope

sources:
  - source/xy_scope_pkg.sv
  - source/raster_timing.sv
  - source/trace_plotter.sv
  - source/frame_store.sv
  - source/scope_regs.sv
  - source/xy_scope_top.sv
  - target: test
    files:
      - testbench/tb_xy_scope.sv
